//--- source/keypad_pkg.sv
package keypad_pkg;

    // matrix geometry
    localparam int ROWS = 4;
    localparam int COLS = 4;
    localparam int KEYS = ROWS * COLS;

    // event queue sizing
    localparam int FIFO_DEPTH = 8;
    localparam int FIFO_AW = 3;

    // events the host can hold before it must return a credit
    localparam int HOST_CREDITS = 4;

    typedef logic [1:0] row_idx_t;
    typedef logic [1:0] col_idx_t;

    // bit row*COLS+col belongs to key (row, col)
    typedef logic [KEYS-1:0] key_vec_t;

    // shared width of all timing and filter counts
    typedef logic [7:0] cfg_byte_t;

    typedef logic [15:0] stamp_t;

    typedef logic [2:0] credit_t;

    // one key edge as seen by the host, 21 bits
    typedef struct packed {
        stamp_t   stamp;
        logic     fall;
        row_idx_t row;
        col_idx_t col;
    } key_event_t;

endpackage

//--- source/keypad_scan_timer.sv
module keypad_scan_timer (
    input  logic                  hready,
    input  logic                  rst_i,
    input  logic                  scan_en_i,
    input  keypad_pkg::cfg_byte_t cfg_step_i,
    input  keypad_pkg::cfg_byte_t cfg_intv_i,
    input  logic                  scan_done_i,
    output logic                  tick_o,
    output logic                  slot_end_o,
    output keypad_pkg::cfg_byte_t phase_o,
    output keypad_pkg::stamp_t    stamp_o
);

    keypad_pkg::cfg_byte_t presc_q;

    // prescaler, one tick every cfg_step+1 cycles
    always_ff @(posedge hready) begin
        if (rst_i || !scan_en_i) begin
            presc_q <= '0;
            tick_o  <= 1'b0;
        end else if (presc_q == cfg_step_i) begin
            presc_q <= '0;
            tick_o  <= 1'b1;
        end else begin
            presc_q <= presc_q + 1'b1;
            tick_o  <= 1'b0;
        end
    end

    // the last tick of a row slot
    assign slot_end_o = tick_o && (phase_o == cfg_intv_i);

    // position of the current tick inside the row slot
    always_ff @(posedge hready) begin
        if (rst_i || !scan_en_i) begin
            phase_o <= '0;
        end else if (slot_end_o) begin
            phase_o <= '0;
        end else if (tick_o) begin
            phase_o <= phase_o + 1'b1;
        end
    end

    // counts full passes over the matrix
    always_ff @(posedge hready) begin
        if (rst_i || !scan_en_i) begin
            stamp_o <= '0;
        end else if (scan_done_i) begin
            stamp_o <= stamp_o + 1'b1;
        end
    end

endmodule

//--- source/keypad_scan_fsm.sv
module keypad_scan_fsm (
    input  logic                        hready,
    input  logic                        rst_i,
    input  logic                        scan_en_i,
    input  logic                        tick_i,
    input  logic                        slot_end_i,
    input  keypad_pkg::cfg_byte_t       phase_i,
    input  keypad_pkg::cfg_byte_t       cfg_predrv_i,
    input  keypad_pkg::cfg_byte_t       cfg_smpl_i,
    input  keypad_pkg::cfg_byte_t       cfg_pstdrv_i,
    output logic [keypad_pkg::ROWS-1:0] row_o,
    output keypad_pkg::row_idx_t        row_sel_o,
    output logic                        sample_o,
    output logic                        scan_done_o
);

    typedef enum logic {
        ST_IDLE,
        ST_SCAN
    } state_t;

    state_t state_q;
    logic   drive_q;
    logic   scanning;

    assign scanning = (state_q == ST_SCAN);

    always_ff @(posedge hready) begin
        if (rst_i || !scan_en_i) begin
            state_q   <= ST_IDLE;
            row_sel_o <= '0;
            drive_q   <= 1'b0;
        end else begin
            state_q <= ST_SCAN;
            if (scanning && slot_end_i) begin
                if (row_sel_o == keypad_pkg::row_idx_t'(keypad_pkg::ROWS - 1)) begin
                    row_sel_o <= '0;
                end else begin
                    row_sel_o <= row_sel_o + 1'b1;
                end
            end
            // pstdrv wins so a window ending on the slot end never leaks into the next row
            if (scanning && tick_i && phase_i == cfg_pstdrv_i) begin
                drive_q <= 1'b0;
            end else if (scanning && tick_i && phase_i == cfg_predrv_i) begin
                drive_q <= 1'b1;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < keypad_pkg::ROWS; i++) begin
            row_o[i] = drive_q && (row_sel_o == keypad_pkg::row_idx_t'(i));
        end
    end

    assign sample_o    = scanning && tick_i && (phase_i == cfg_smpl_i);
    assign scan_done_o = scanning && slot_end_i &&
                         (row_sel_o == keypad_pkg::row_idx_t'(keypad_pkg::ROWS - 1));

    // the drive window must close before the next row's slot begins
    row_released: assert property (@(posedge hready) disable iff (rst_i)
        slot_end_i |=> row_o == '0);

    // the sample point must fall inside the drive window of its row
    sample_in_window: assert property (@(posedge hready) disable iff (rst_i)
        sample_o |-> row_o != '0);

endmodule

//--- source/keypad_debounce.sv
module keypad_debounce (
    input  logic                        hready,
    input  logic                        rst_i,
    input  logic                        scan_en_i,
    input  logic                        sample_i,
    input  keypad_pkg::row_idx_t        row_sel_i,
    input  logic [keypad_pkg::COLS-1:0] col_i,
    input  keypad_pkg::cfg_byte_t       cfg_filter_i,
    output keypad_pkg::key_vec_t        stable_o,
    output logic                        commit_o,
    output keypad_pkg::row_idx_t        commit_row_o,
    output logic [keypad_pkg::COLS-1:0] rise_o,
    output logic [keypad_pkg::COLS-1:0] fall_o
);

    keypad_pkg::key_vec_t        smp_q;
    keypad_pkg::key_vec_t        prv_q;
    keypad_pkg::cfg_byte_t       cnt_q [keypad_pkg::KEYS];
    keypad_pkg::cfg_byte_t       cnt_nx [keypad_pkg::COLS];
    logic [keypad_pkg::COLS-1:0] settled;
    logic                        eval_q;
    keypad_pkg::row_idx_t        eval_row_q;
    int                          smp_base;
    int                          eval_base;

    assign smp_base  = int'(row_sel_i) * keypad_pkg::COLS;
    assign eval_base = int'(eval_row_q) * keypad_pkg::COLS;

    // filter step for the row under evaluation
    always_comb begin
        for (int c = 0; c < keypad_pkg::COLS; c++) begin
            if (smp_q[eval_base + c] != prv_q[eval_base + c]) begin
                cnt_nx[c] = '0;
            end else if (cnt_q[eval_base + c] != cfg_filter_i) begin
                cnt_nx[c] = cnt_q[eval_base + c] + 1'b1;
            end else begin
                cnt_nx[c] = cnt_q[eval_base + c];
            end
            settled[c] = (cnt_nx[c] == cfg_filter_i);
        end
    end

    always_ff @(posedge hready) begin
        if (rst_i || !scan_en_i) begin
            smp_q        <= '0;
            prv_q        <= '0;
            stable_o     <= '0;
            eval_q       <= 1'b0;
            eval_row_q   <= '0;
            commit_o     <= 1'b0;
            commit_row_o <= '0;
            rise_o       <= '0;
            fall_o       <= '0;
            for (int k = 0; k < keypad_pkg::KEYS; k++) begin
                cnt_q[k] <= '0;
            end
        end else begin
            eval_q   <= sample_i;
            commit_o <= eval_q;
            rise_o   <= '0;
            fall_o   <= '0;
            // capture the columns of the driven row
            if (sample_i) begin
                eval_row_q <= row_sel_i;
                for (int c = 0; c < keypad_pkg::COLS; c++) begin
                    smp_q[smp_base + c] <= col_i[c];
                    prv_q[smp_base + c] <= smp_q[smp_base + c];
                end
            end
            if (eval_q) begin
                commit_row_o <= eval_row_q;
                for (int c = 0; c < keypad_pkg::COLS; c++) begin
                    cnt_q[eval_base + c] <= cnt_nx[c];
                    if (settled[c]) begin
                        stable_o[eval_base + c] <= smp_q[eval_base + c];
                        rise_o[c] <= smp_q[eval_base + c] && !stable_o[eval_base + c];
                        fall_o[c] <= !smp_q[eval_base + c] && stable_o[eval_base + c];
                    end
                end
            end
        end
    end

endmodule

//--- source/keypad_event_encoder.sv
module keypad_event_encoder (
    input  logic                        hready,
    input  logic                        rst_i,
    input  logic                        scan_en_i,
    input  logic                        commit_i,
    input  keypad_pkg::row_idx_t        commit_row_i,
    input  logic [keypad_pkg::COLS-1:0] rise_i,
    input  logic [keypad_pkg::COLS-1:0] fall_i,
    input  keypad_pkg::key_vec_t        rise_en_i,
    input  keypad_pkg::key_vec_t        fall_en_i,
    input  keypad_pkg::stamp_t          stamp_i,
    output logic                        push_o,
    output keypad_pkg::key_event_t      push_data_o
);

    logic [keypad_pkg::COLS-1:0] rise_pend_q;
    logic [keypad_pkg::COLS-1:0] fall_pend_q;
    logic [keypad_pkg::COLS-1:0] pend;
    keypad_pkg::row_idx_t        row_q;
    keypad_pkg::col_idx_t        col_sel;
    int                          base;

    assign base = int'(commit_row_i) * keypad_pkg::COLS;
    assign pend = rise_pend_q | fall_pend_q;

    // lowest pending column goes first
    always_comb begin
        col_sel = '0;
        for (int c = keypad_pkg::COLS - 1; c >= 0; c--) begin
            if (pend[c]) begin
                col_sel = keypad_pkg::col_idx_t'(c);
            end
        end
    end

    assign push_o = |pend;

    always_comb begin
        push_data_o.stamp = stamp_i;
        push_data_o.fall  = !rise_pend_q[col_sel];
        push_data_o.row   = row_q;
        push_data_o.col   = col_sel;
    end

    always_ff @(posedge hready) begin
        if (rst_i || !scan_en_i) begin
            rise_pend_q <= '0;
            fall_pend_q <= '0;
        end else if (commit_i) begin
            rise_pend_q <= rise_i & rise_en_i[base +: keypad_pkg::COLS];
            fall_pend_q <= fall_i & fall_en_i[base +: keypad_pkg::COLS];
        end else if (push_o) begin
            if (rise_pend_q[col_sel]) begin
                rise_pend_q[col_sel] <= 1'b0;
            end else begin
                fall_pend_q[col_sel] <= 1'b0;
            end
        end
    end

    always_ff @(posedge hready) begin
        if (commit_i) begin
            row_q <= commit_row_i;
        end
    end

endmodule

//--- source/keypad_event_queue.sv
module keypad_event_queue (
    input  logic                   hready,
    input  logic                   rst_i,
    input  logic                   push_i,
    input  keypad_pkg::key_event_t push_data_i,
    input  logic                   credit_i,
    output logic                   evt_valid_o,
    output keypad_pkg::key_event_t evt_data_o
);

    keypad_pkg::key_event_t         mem [keypad_pkg::FIFO_DEPTH];
    logic [keypad_pkg::FIFO_AW-1:0] wr_ptr;
    logic [keypad_pkg::FIFO_AW-1:0] rd_ptr;
    logic [keypad_pkg::FIFO_AW:0]   count;
    keypad_pkg::credit_t            credits;
    logic                           full;
    logic                           empty;
    logic                           wr;
    logic                           rd;

    assign full  = (count == keypad_pkg::FIFO_DEPTH);
    assign empty = (count == '0);
    // events arriving on a full queue are lost
    assign wr    = push_i && !full;
    assign rd    = !empty && (credits != '0);

    always_ff @(posedge hready) begin
        if (wr) begin
            mem[wr_ptr] <= push_data_i;
        end
    end

    always_ff @(posedge hready) begin
        if (rd) begin
            evt_data_o <= mem[rd_ptr];
        end
    end

    always_ff @(posedge hready) begin
        if (rst_i) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            credits     <= keypad_pkg::credit_t'(keypad_pkg::HOST_CREDITS);
            evt_valid_o <= 1'b0;
        end else begin
            evt_valid_o <= rd;
            if (wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr, rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // one credit spent per delivery, one returned per host pulse
            credits <= credits + keypad_pkg::credit_t'(credit_i)
                               - keypad_pkg::credit_t'(rd);
        end
    end

    credit_bound: assert property (@(posedge hready) disable iff (rst_i)
        credit_i |=> credits <= keypad_pkg::credit_t'(keypad_pkg::HOST_CREDITS));

endmodule

//--- source/keypad_scanner.sv
module keypad_scanner (
    input  logic                        hready,
    input  logic                        rst_i,
    input  logic                        scan_en_i,
    input  keypad_pkg::cfg_byte_t       cfg_step_i,
    input  keypad_pkg::cfg_byte_t       cfg_predrv_i,
    input  keypad_pkg::cfg_byte_t       cfg_smpl_i,
    input  keypad_pkg::cfg_byte_t       cfg_pstdrv_i,
    input  keypad_pkg::cfg_byte_t       cfg_intv_i,
    input  keypad_pkg::cfg_byte_t       cfg_filter_i,
    input  keypad_pkg::key_vec_t        rise_en_i,
    input  keypad_pkg::key_vec_t        fall_en_i,
    input  logic [keypad_pkg::COLS-1:0] col_i,
    output logic [keypad_pkg::ROWS-1:0] row_o,
    output logic                        evt_valid_o,
    output keypad_pkg::key_event_t      evt_data_o,
    input  logic                        credit_i
);

    logic                        tick;
    logic                        slot_end;
    logic                        scan_done;
    logic                        sample;
    logic                        commit;
    logic                        push;
    keypad_pkg::cfg_byte_t       phase;
    keypad_pkg::stamp_t          stamp;
    keypad_pkg::row_idx_t        row_sel;
    keypad_pkg::row_idx_t        commit_row;
    logic [keypad_pkg::COLS-1:0] rise;
    logic [keypad_pkg::COLS-1:0] fall;
    keypad_pkg::key_event_t      push_data;

    keypad_scan_timer u_timer (
        .hready, .rst_i, .scan_en_i, .cfg_step_i, .cfg_intv_i,
        .scan_done_i (scan_done),
        .tick_o      (tick),
        .slot_end_o  (slot_end),
        .phase_o     (phase),
        .stamp_o     (stamp)
    );

    keypad_scan_fsm u_fsm (
        .hready, .rst_i, .scan_en_i, .cfg_predrv_i, .cfg_smpl_i, .cfg_pstdrv_i,
        .tick_i      (tick),
        .slot_end_i  (slot_end),
        .phase_i     (phase),
        .row_o,
        .row_sel_o   (row_sel),
        .sample_o    (sample),
        .scan_done_o (scan_done)
    );

    // the debounced key map stays internal
    keypad_debounce u_debounce (
        .hready, .rst_i, .scan_en_i, .col_i, .cfg_filter_i,
        .sample_i     (sample),
        .row_sel_i    (row_sel),
        .stable_o     (),
        .commit_o     (commit),
        .commit_row_o (commit_row),
        .rise_o       (rise),
        .fall_o       (fall)
    );

    keypad_event_encoder u_encoder (
        .hready, .rst_i, .scan_en_i, .rise_en_i, .fall_en_i,
        .commit_i     (commit),
        .commit_row_i (commit_row),
        .rise_i       (rise),
        .fall_i       (fall),
        .stamp_i      (stamp),
        .push_o       (push),
        .push_data_o  (push_data)
    );

    keypad_event_queue u_queue (
        .hready, .rst_i, .credit_i, .evt_valid_o, .evt_data_o,
        .push_i      (push),
        .push_data_i (push_data)
    );

endmodule

//--- verif/keypad_scanner_tb.sv
module keypad_scanner_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam keypad_pkg::cfg_byte_t CFG_STEP   = 8'd1;
    localparam keypad_pkg::cfg_byte_t CFG_PREDRV = 8'd1;
    localparam keypad_pkg::cfg_byte_t CFG_SMPL   = 8'd3;
    localparam keypad_pkg::cfg_byte_t CFG_PSTDRV = 8'd5;
    localparam keypad_pkg::cfg_byte_t CFG_INTV   = 8'd6;
    localparam keypad_pkg::cfg_byte_t CFG_FILTER = 8'd1;

    localparam int SLOT_CYCLES = (int'(CFG_STEP) + 1) * (int'(CFG_INTV) + 1);
    localparam int SCAN_CYCLES = SLOT_CYCLES * keypad_pkg::ROWS;

    logic                        hready;
    logic                        rst;
    logic                        scan_en;
    keypad_pkg::key_vec_t        rise_en;
    keypad_pkg::key_vec_t        fall_en;
    logic [keypad_pkg::COLS-1:0] col;
    logic [keypad_pkg::ROWS-1:0] row;
    logic                        evt_valid;
    keypad_pkg::key_event_t      evt_data;
    logic                        credit;
    keypad_pkg::key_vec_t        pressed;

    // golden commands, one entry per line
    logic [7:0]             op_q[$];
    logic [15:0]            arg_a_q[$];
    logic [15:0]            arg_b_q[$];
    logic [15:0]            arg_c_q[$];

    keypad_pkg::key_event_t got_q[$];
    keypad_pkg::key_event_t exp_q[$];
    int                     grp_q[$];
    // cycle numbers at which a credit goes back to the DUT
    int                     owed_q[$];

    int                     cycle = 0;
    int                     group = 0;
    int                     held = 0;
    int                     last_grp = 0;
    int                     watchdog_cycles = 0;
    logic                   credits_on = 1'b1;
    logic                   have_stamp = 1'b0;
    keypad_pkg::stamp_t     last_stamp = '0;
    logic [31:0]            lfsr = 32'h880d8f5a;

    keypad_scanner u_dut (
        .hready       (hready),
        .rst_i        (rst),
        .scan_en_i    (scan_en),
        .cfg_step_i   (CFG_STEP),
        .cfg_predrv_i (CFG_PREDRV),
        .cfg_smpl_i   (CFG_SMPL),
        .cfg_pstdrv_i (CFG_PSTDRV),
        .cfg_intv_i   (CFG_INTV),
        .cfg_filter_i (CFG_FILTER),
        .rise_en_i    (rise_en),
        .fall_en_i    (fall_en),
        .col_i        (col),
        .row_o        (row),
        .evt_valid_o  (evt_valid),
        .evt_data_o   (evt_data),
        .credit_i     (credit)
    );

    always #50 hready = !hready;

    // a pressed key shorts its column to its row
    always_comb begin
        col = '0;
        for (int r = 0; r < keypad_pkg::ROWS; r++) begin
            for (int c = 0; c < keypad_pkg::COLS; c++) begin
                if (row[r] && pressed[r * keypad_pkg::COLS + c]) begin
                    col[c] = 1'b1;
                end
            end
        end
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped at %0t", $time);
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_delay(output int cycles);
        logic [1:0] v;
        for (int i = 0; i < 2; i++) begin
            lfsr = lfsr_next(lfsr);
            v[i] = lfsr[0];
        end
        cycles = (v == 2'd0) ? 1 : int'(v);
    endtask

    task automatic wait_scans(input int scans);
        repeat (scans * SCAN_CYCLES) @(posedge hready);
        #1;
    endtask

    task automatic expect_event(input int r, input int c, input logic fall);
        keypad_pkg::key_event_t ev;
        ev.stamp = '0;
        ev.fall  = fall;
        ev.row   = keypad_pkg::row_idx_t'(r);
        ev.col   = keypad_pkg::col_idx_t'(c);
        exp_q.push_back(ev);
        grp_q.push_back(group);
    endtask

    task automatic check_event(input keypad_pkg::key_event_t got,
                               input keypad_pkg::key_event_t exp);
        if (got.row != exp.row || got.col != exp.col || got.fall != exp.fall) begin
            fail_run($sformatf({"** Error evt_data_o: row 0x%h col 0x%h fall 0x%h,",
                                " expected row 0x%h col 0x%h fall 0x%h"},
                               got.row, got.col, got.fall, exp.row, exp.col, exp.fall));
        end
    endtask

    // a new scan must carry a later stamp, events of one scan may share it
    task automatic check_stamp(input keypad_pkg::stamp_t got,
                               input keypad_pkg::stamp_t prev,
                               input logic new_scan);
        if (got < prev || (new_scan && got == prev)) begin
            fail_run($sformatf("** Error evt_data_o.stamp: 0x%h after 0x%h", got, prev));
        end
    endtask

    // one row at most is driven, and none while scanning is off
    task automatic check_rows(input logic [keypad_pkg::ROWS-1:0] got,
                              input logic enabled);
        if (!$onehot0(got) || (!enabled && got != '0)) begin
            fail_run($sformatf("** Error row_o: 0x%h with scan enable 0x%h, expected one hot",
                               got, enabled));
        end
    endtask

    task automatic compare_pending();
        keypad_pkg::key_event_t got;
        keypad_pkg::key_event_t exp;
        int                     grp;
        while (got_q.size() != 0 && exp_q.size() != 0) begin
            got = got_q.pop_front();
            exp = exp_q.pop_front();
            grp = grp_q.pop_front();
            check_event(got, exp);
            if (have_stamp) begin
                check_stamp(got.stamp, last_stamp, grp != last_grp);
            end
            have_stamp = 1'b1;
            last_stamp = got.stamp;
            last_grp   = grp;
        end
    endtask

    // outputs are registered, so the falling edge sees them settled
    always @(negedge hready) begin : monitor
        int delay;
        check_rows(row, scan_en);
        if (!rst && evt_valid) begin
            got_q.push_back(evt_data);
            draw_delay(delay);
            owed_q.push_back(cycle + delay);
            if (!credits_on) begin
                held = held + 1;
                if (held > keypad_pkg::HOST_CREDITS) begin
                    fail_run($sformatf("%0d events delivered while credits were withheld",
                                       held));
                end
            end
        end
        compare_pending();
    end

    always @(posedge hready) begin
        cycle = cycle + 1;
        #1;
        credit = 1'b0;
        if (credits_on && owed_q.size() != 0 && owed_q[0] <= cycle) begin
            credit = 1'b1;
            void'(owed_q.pop_front());
        end
    end

    initial begin : watchdog
        wait (watchdog_cycles != 0);
        repeat (watchdog_cycles) @(posedge hready);
        fail_run("watchdog expired before the golden file was done");
    end

    initial begin : main
        int          fd;
        int          key;
        logic [7:0]  op;
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] c;
        hready  = 1'b0;
        rst     = 1'b1;
        scan_en = 1'b0;
        rise_en = '1;
        fall_en = '1;
        pressed = '0;
        credit  = 1'b0;
        fd = $fopen("verif/keypad_golden.txt", "r");
        if (fd == 0) begin
            fail_run("cannot open verif/keypad_golden.txt");
        end
        while ($fscanf(fd, " %c %h %h %h", op, a, b, c) == 4) begin
            op_q.push_back(op);
            arg_a_q.push_back(a);
            arg_b_q.push_back(b);
            arg_c_q.push_back(c);
        end
        $fclose(fd);
        watchdog_cycles = op_q.size() * 10 * SLOT_CYCLES * keypad_pkg::ROWS * 2;
        repeat (10) @(posedge hready);
        #1;
        rst     = 1'b0;
        scan_en = 1'b1;
        for (int i = 0; i < op_q.size(); i++) begin
            case (op_q[i])
                // tap: press, ten scans, release, ten scans
                "t": begin
                    key   = int'(arg_a_q[i]);
                    group = group + 1;
                    if (arg_b_q[i] != 0) begin
                        expect_event(key / keypad_pkg::COLS, key % keypad_pkg::COLS, 1'b0);
                    end
                    pressed[key] = 1'b1;
                    wait_scans(10);
                    group = group + 1;
                    if (arg_c_q[i] != 0) begin
                        expect_event(key / keypad_pkg::COLS, key % keypad_pkg::COLS, 1'b1);
                    end
                    pressed[key] = 1'b0;
                    wait_scans(10);
                end
                "k": begin
                    group   = group + 1;
                    pressed = arg_a_q[i];
                    wait_scans(10);
                end
                "x": begin
                    expect_event(int'(arg_a_q[i]), int'(arg_b_q[i]), arg_c_q[i][0]);
                end
                "e": begin
                    rise_en = arg_a_q[i];
                    fall_en = arg_b_q[i];
                end
                "w": begin
                    credits_on = 1'b0;
                    held       = 0;
                end
                "c": begin
                    credits_on = 1'b1;
                end
                default: begin
                    fail_run($sformatf("unknown golden command %c", op_q[i]));
                end
            endcase
        end
        // let withheld events drain
        wait_scans(2);
        if (exp_q.size() != 0) begin
            fail_run($sformatf("%0d expected events never arrived", exp_q.size()));
        end else if (got_q.size() != 0) begin
            fail_run($sformatf("%0d events arrived that were not expected", got_q.size()));
        end else begin
            $display("NO ERRORS");
            $finish;
        end
    end

endmodule

//--- verif/keypad_golden.txt
t 0 1 1
t 1 1 1
t 2 1 1
t 3 1 1
t 4 1 1
t 5 1 1
t 6 1 1
t 7 1 1
t 8 1 1
t 9 1 1
t a 1 1
t b 1 1
t c 1 1
t d 1 1
t e 1 1
t f 1 1
e ffdf fbff 0
t 5 0 1
t a 1 0
t 6 1 1
e ffff ffff 0
k 0006 0 0
x 0 1 0
x 0 2 0
k 0000 0 0
x 0 1 1
x 0 2 1
w 0 0 0
k 00f0 0 0
x 1 0 0
x 1 1 0
x 1 2 0
x 1 3 0
k 0000 0 0
x 1 0 1
x 1 1 1
x 1 2 1
x 1 3 1
c 0 0 0

//--- keypad_scanner.f
source/keypad_pkg.sv
source/keypad_scan_timer.sv
source/keypad_scan_fsm.sv
source/keypad_debounce.sv
source/keypad_event_encoder.sv
source/keypad_event_queue.sv
source/keypad_scanner.sv
verif/keypad_scanner_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= keypad_scanner_tb
FILELIST  ?= keypad_scanner.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 4
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal

SOURCES := $(shell cat $(FILELIST))
SIM_EXE := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_EXE)

$(SIM_EXE): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_EXE)
	./$(SIM_EXE)

clean:
	rm -rf $(OBJ_DIR)
